// File: logic/dmm_defs.svh
// dmm front end widths, register map size and mode codes shared by rtl and testbench
`ifndef DMM_DEFS_SVH
`define DMM_DEFS_SVH

//////////////////////////////////////////////////
// spi frame and register widths

`define DMM_DATA_W    32      // register width
`define DMM_ADDR_W    8       // address byte, msb is write flag
`define DMM_REG_N     11      // highest mapped address, status
`define DMM_MAGIC     8'hAA   // status byte 0

//////////////////////////////////////////////////
// sequencer and mock adc

`define DMM_COUNT_W   24      // precharge and aperture clk counts
`define DMM_SEQ_MAX   4       // sequence words available
`define DMM_SEQ_W     6       // azmux 3:0, pc_sw 5:4
`define DMM_IDX_W     3       // seq_n and sample index
`define DMM_FLAGS_W   4       // board hw flags

// mode and spi target field widths
`define DMM_MODE_W    3
`define DMM_SPI_W     4
`define DMM_MODE_DIRECT   3'd0
`define DMM_MODE_ACQ_MOCK 3'd6

`endif

// File: logic/dmm_pkg.sv
// dmm front end types: register map, modes, spi targets, config and pin bundles
`default_nettype none
`include "dmm_defs.svh"

package dmm_pkg;

  // register addresses, low 7 bits of the address byte
  typedef enum logic [`DMM_ADDR_W-2:0] {
    REG_SPI_MUX   = 1,
    REG_MODE      = 2,
    REG_DIRECT    = 3,
    REG_SEQ_N     = 4,
    REG_SEQ0      = 5,
    REG_SEQ1      = 6,
    REG_SEQ2      = 7,
    REG_SEQ3      = 8,
    REG_PRECHARGE = 9,
    REG_APERTURE  = 10,
    REG_STATUS    = `DMM_REG_N   // read only
  } reg_addr_e;

  typedef enum logic [`DMM_MODE_W-1:0] {
    MODE_DIRECT   = `DMM_MODE_DIRECT,
    MODE_ACQ_MOCK = `DMM_MODE_ACQ_MOCK
  } mode_e;

  // one-hot peripheral select on the shared bus
  typedef enum logic [`DMM_SPI_W-1:0] {
    SPI_NONE        = 4'b0000,
    SPI_STROBE_4094 = 4'b0001,
    SPI_DAC         = 4'b0010,
    SPI_ISO_DAC     = 4'b0100,
    SPI_ISO_DAC2    = 4'b1000
  } spi_target_e;

  typedef enum logic [1:0] {
    ACQ_IDLE,
    ACQ_PRECHARGE,
    ACQ_MEASURE
  } acq_state_e;

  typedef struct packed {
    mode_e                                     mode;
    spi_target_e                               spi_mux;
    logic [`DMM_DATA_W-1:0]                    direct;
    logic [`DMM_IDX_W-1:0]                     seq_n;
    logic [`DMM_SEQ_MAX-1:0][`DMM_SEQ_W-1:0]   seq;        // az/pc switch settings
    logic [`DMM_COUNT_W-1:0]                   precharge;
    logic [`DMM_COUNT_W-1:0]                   aperture;
  } dmm_cfg_t;

  // board outputs, msb first so leds land on bit 0 like the direct register
  typedef struct packed {
    logic       spi_interrupt;   // 18
    logic [3:0] azmux;           // 17:14
    logic [1:0] pc_sw;           // 13:12
    logic [7:0] monitor;         // 11:4
    logic [3:0] leds;            // 3:0
  } pins_t;

  typedef struct packed {
    logic glb_clk;
    logic glb_mosi;
    logic strobe_4094;     // active hi
    logic dac_cs_n;
    logic iso_dac_cs_n;
    logic iso_dac2_cs_n;
  } spi_pins_t;

endpackage

`default_nettype wire

// File: logic/spi_reg_bank.sv
// spi mode 0 slave with config registers in the sck domain and a read-only status word
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module spi_reg_bank (
  input  wire                        sck_i,
  input  wire                        cs_n_i,
  input  wire                        mosi_i,
  input  wire                        rst_n_i,
  output logic                       miso_o,
  input  wire [`DMM_FLAGS_W-1:0]     hw_flags_i,
  input  wire [`DMM_IDX_W-1:0]       sample_idx_last_i,
  output dmm_pkg::dmm_cfg_t          cfg_o
);

  localparam int FRAME_BITS = `DMM_ADDR_W + `DMM_DATA_W;   // 40
  localparam int CNT_W      = $clog2(FRAME_BITS + 1);

  logic                     frame_rst_n;
  logic [CNT_W-1:0]         bit_cnt_q;    // rising edges seen this frame
  logic [`DMM_DATA_W-2:0]   shift_q;      // mosi history, newest bit comes from the pin
  logic [`DMM_ADDR_W-1:0]   addr_q;
  logic [`DMM_ADDR_W-1:0]   addr_byte;
  logic [`DMM_DATA_W-1:0]   wr_data;
  logic [`DMM_DATA_W-1:0]   rd_sr_q;      // readback shifter
  logic [`DMM_DATA_W-1:0]   rd_val;
  logic [`DMM_DATA_W-1:0]   status;
  logic                     addr_done;
  logic                     wr_en;
  dmm_pkg::dmm_cfg_t        cfg_q;

  assign frame_rst_n = rst_n_i & ~cs_n_i;              // frame state clears while deselected
  assign addr_byte   = {shift_q[`DMM_ADDR_W-2:0], mosi_i};
  assign wr_data     = {shift_q, mosi_i};
  assign addr_done   = (bit_cnt_q == CNT_W'(`DMM_ADDR_W - 1));    // 8th edge
  assign wr_en       = (bit_cnt_q == CNT_W'(FRAME_BITS - 1))      // 40th edge
                     && addr_q[`DMM_ADDR_W-1];                    // write flag

  //////////////////////////////////////////////////
  // frame shifting

  always_ff @(posedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      bit_cnt_q <= '0;
    end else if (bit_cnt_q != CNT_W'(FRAME_BITS)) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;   // saturate, long frames do nothing more
    end
  end

  always_ff @(posedge sck_i) begin
    shift_q <= wr_data[`DMM_DATA_W-2:0];
    if (addr_done) begin
      addr_q  <= addr_byte;
      rd_sr_q <= rd_val;                // capture addressed value
    end else begin
      rd_sr_q <= {rd_sr_q[`DMM_DATA_W-2:0], 1'b0};
    end
  end

  // sdo changes on the falling edge, 0 during the address byte
  always_ff @(negedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      miso_o <= 1'b0;
    end else if (bit_cnt_q >= CNT_W'(`DMM_ADDR_W)) begin
      miso_o <= rd_sr_q[`DMM_DATA_W-1];
    end else begin
      miso_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // readback

  assign status = {9'b0, cfg_q.seq_n, 1'b0, sample_idx_last_i,   // 22:20, 18:16
                   cfg_q.spi_mux, hw_flags_i, `DMM_MAGIC};       // 15:12, 11:8, 7:0

  always_comb begin
    rd_val = '0;   // unmapped reads as zero
    case (dmm_pkg::reg_addr_e'(addr_byte[`DMM_ADDR_W-2:0]))
      dmm_pkg::REG_SPI_MUX:   rd_val = `DMM_DATA_W'(cfg_q.spi_mux);
      dmm_pkg::REG_MODE:      rd_val = `DMM_DATA_W'(cfg_q.mode);
      dmm_pkg::REG_DIRECT:    rd_val = cfg_q.direct;
      dmm_pkg::REG_SEQ_N:     rd_val = `DMM_DATA_W'(cfg_q.seq_n);
      dmm_pkg::REG_SEQ0:      rd_val = `DMM_DATA_W'(cfg_q.seq[0]);
      dmm_pkg::REG_SEQ1:      rd_val = `DMM_DATA_W'(cfg_q.seq[1]);
      dmm_pkg::REG_SEQ2:      rd_val = `DMM_DATA_W'(cfg_q.seq[2]);
      dmm_pkg::REG_SEQ3:      rd_val = `DMM_DATA_W'(cfg_q.seq[3]);
      dmm_pkg::REG_PRECHARGE: rd_val = `DMM_DATA_W'(cfg_q.precharge);
      dmm_pkg::REG_APERTURE:  rd_val = `DMM_DATA_W'(cfg_q.aperture);
      dmm_pkg::REG_STATUS:    rd_val = status;
      default:                rd_val = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // config writes, only on a complete write frame

  always_ff @(posedge sck_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_q <= '0;   // direct mode with all outputs low, bus parked
    end else if (wr_en) begin
      case (dmm_pkg::reg_addr_e'(addr_q[`DMM_ADDR_W-2:0]))
        dmm_pkg::REG_SPI_MUX:   cfg_q.spi_mux   <= dmm_pkg::spi_target_e'(wr_data[`DMM_SPI_W-1:0]);
        dmm_pkg::REG_MODE:      cfg_q.mode      <= dmm_pkg::mode_e'(wr_data[`DMM_MODE_W-1:0]);
        dmm_pkg::REG_DIRECT:    cfg_q.direct    <= wr_data;
        dmm_pkg::REG_SEQ_N:     cfg_q.seq_n     <= wr_data[`DMM_IDX_W-1:0];
        dmm_pkg::REG_SEQ0:      cfg_q.seq[0]    <= wr_data[`DMM_SEQ_W-1:0];
        dmm_pkg::REG_SEQ1:      cfg_q.seq[1]    <= wr_data[`DMM_SEQ_W-1:0];
        dmm_pkg::REG_SEQ2:      cfg_q.seq[2]    <= wr_data[`DMM_SEQ_W-1:0];
        dmm_pkg::REG_SEQ3:      cfg_q.seq[3]    <= wr_data[`DMM_SEQ_W-1:0];
        dmm_pkg::REG_PRECHARGE: cfg_q.precharge <= wr_data[`DMM_COUNT_W-1:0];
        dmm_pkg::REG_APERTURE:  cfg_q.aperture  <= wr_data[`DMM_COUNT_W-1:0];
        default: ;   // status is read only
      endcase
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: logic/acq_sequencer.sv
// acquisition sequencer stepping az/precharge settings, precharge hold then mock adc measure
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module acq_sequencer (
  input  wire                       clk_i,
  input  wire                       rst_n_i,
  input  wire                       trig_sa_i,
  input  wire dmm_pkg::dmm_cfg_t    cfg_i,
  input  wire                       measure_valid_i,
  output logic                      adc_reset_n_o,
  output dmm_pkg::pins_t            seq_pins_o,
  output logic [`DMM_IDX_W-1:0]     sample_idx_last_o
);

  localparam int SEL_W = $clog2(`DMM_SEQ_MAX);

  logic                      trig_meta_q;
  logic                      trig_q;       // synchronized trigger level
  dmm_pkg::acq_state_e       state_q;
  logic [`DMM_COUNT_W-1:0]   pc_cnt_q;     // precharge cycles left
  logic [`DMM_IDX_W-1:0]     idx_q;
  logic [`DMM_IDX_W-1:0]     idx_next;
  logic [`DMM_IDX_W-1:0]     seq_len;
  logic [`DMM_SEQ_W-1:0]     seq_word;
  logic                      sample_done;

  // trig from the mcu is async
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trig_meta_q <= 1'b0;
      trig_q      <= 1'b0;
    end else begin
      trig_meta_q <= trig_sa_i;
      trig_q      <= trig_meta_q;
    end
  end

  // seq_n of 0 runs one word, anything past the word count clamps
  always_comb begin
    if (cfg_i.seq_n == '0) begin
      seq_len = `DMM_IDX_W'(1);
    end else if (cfg_i.seq_n > `DMM_IDX_W'(`DMM_SEQ_MAX)) begin
      seq_len = `DMM_IDX_W'(`DMM_SEQ_MAX);
    end else begin
      seq_len = cfg_i.seq_n;
    end
  end

  assign idx_next    = (idx_q + 1'b1 >= seq_len) ? '0 : idx_q + 1'b1;
  assign seq_word    = cfg_i.seq[idx_q[SEL_W-1:0]];
  assign sample_done = measure_valid_i && (state_q == dmm_pkg::ACQ_MEASURE);

  //////////////////////////////////////////////////
  // fsm

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q           <= dmm_pkg::ACQ_IDLE;
      pc_cnt_q          <= '0;
      idx_q             <= '0;
      sample_idx_last_o <= '0;
    end else begin
      case (state_q)
        dmm_pkg::ACQ_IDLE: begin
          if (trig_q) begin
            state_q  <= dmm_pkg::ACQ_PRECHARGE;
            pc_cnt_q <= cfg_i.precharge;
            idx_q    <= '0;   // each run starts at seq0
          end
        end
        dmm_pkg::ACQ_PRECHARGE: begin
          if (!trig_q) begin
            state_q <= dmm_pkg::ACQ_IDLE;
          end else if (pc_cnt_q <= `DMM_COUNT_W'(1)) begin
            state_q <= dmm_pkg::ACQ_MEASURE;   // zero count still gives one cycle
          end else begin
            pc_cnt_q <= pc_cnt_q - 1'b1;
          end
        end
        dmm_pkg::ACQ_MEASURE: begin
          if (sample_done) begin
            sample_idx_last_o <= idx_q;
            idx_q             <= idx_next;
            pc_cnt_q          <= cfg_i.precharge;
            state_q           <= trig_q ? dmm_pkg::ACQ_PRECHARGE : dmm_pkg::ACQ_IDLE;
          end else if (!trig_q) begin
            state_q <= dmm_pkg::ACQ_IDLE;   // abandon partial sample
          end
        end
        default: state_q <= dmm_pkg::ACQ_IDLE;
      endcase
    end
  end

  assign adc_reset_n_o = (state_q == dmm_pkg::ACQ_MEASURE);   // adc held in reset otherwise

  always_comb begin
    seq_pins_o                        = '0;
    seq_pins_o.spi_interrupt          = sample_done;   // one cycle, sample still on azmux
    seq_pins_o.azmux                  = seq_word[3:0];
    seq_pins_o.pc_sw                  = seq_word[5:4];
    seq_pins_o.monitor                = {1'b0, idx_q, measure_valid_i, adc_reset_n_o, state_q};
    seq_pins_o.leds[idx_q[SEL_W-1:0]] = 1'b1;          // one-hot sample index
  end

endmodule

`default_nettype wire

// File: logic/adc_mock.sv
// mock adc, counts an aperture after reset release and pulses measure valid once
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module adc_mock (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  wire                      adc_reset_n_i,
  input  wire [`DMM_COUNT_W-1:0]   aperture_i,
  output logic                     measure_valid_o
);

  logic [`DMM_COUNT_W-1:0] cnt_q;
  logic                    done_q;   // holds off until the next adc reset
  logic                    hit;

  assign hit = adc_reset_n_i && !done_q && (cnt_q == aperture_i);

  // valid lands aperture + 1 clks after reset release
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q           <= '0;
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else if (!adc_reset_n_i) begin
      cnt_q           <= '0;     // held in reset by the sequencer
      done_q          <= 1'b0;
      measure_valid_o <= 1'b0;
    end else begin
      measure_valid_o <= hit;
      if (hit) begin
        done_q <= 1'b1;
      end else if (!done_q) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/pin_mux.sv
// board output mode select and shared spi bus routing to the peripheral chip selects
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module pin_mux (
  input  wire dmm_pkg::dmm_cfg_t   cfg_i,
  input  wire dmm_pkg::pins_t      seq_pins_i,
  input  wire                      sck_i,
  input  wire                      mosi_i,
  input  wire                      cs2_n_i,
  output dmm_pkg::pins_t           pins_o,
  output dmm_pkg::spi_pins_t       spi_pins_o
);

  localparam int PINS_W = $bits(dmm_pkg::pins_t);   // low bits of direct

  logic park;   // no target, bus idles high

  //////////////////////////////////////////////////
  // mode, alternate function select

  always_comb begin
    case (cfg_i.mode)
      dmm_pkg::MODE_DIRECT:   pins_o = dmm_pkg::pins_t'(cfg_i.direct[PINS_W-1:0]);
      dmm_pkg::MODE_ACQ_MOCK: pins_o = seq_pins_i;   // sequencer with mock adc
      default:                pins_o = '0;           // unused modes drive low
    endcase
  end

  //////////////////////////////////////////////////
  // spi peripheral routing

  assign park = (cfg_i.spi_mux == dmm_pkg::SPI_NONE);

  always_comb begin
    spi_pins_o.glb_clk  = park ? 1'b1 : sck_i;
    spi_pins_o.glb_mosi = park ? 1'b1 : mosi_i;

    // 4094 strobe is active hi so it takes the inverted cs, park lo
    spi_pins_o.strobe_4094 = (cfg_i.spi_mux == dmm_pkg::SPI_STROBE_4094) ? ~cs2_n_i : 1'b0;

    // dac selects active lo, park hi
    spi_pins_o.dac_cs_n      = (cfg_i.spi_mux == dmm_pkg::SPI_DAC)      ? cs2_n_i : 1'b1;
    spi_pins_o.iso_dac_cs_n  = (cfg_i.spi_mux == dmm_pkg::SPI_ISO_DAC)  ? cs2_n_i : 1'b1;
    spi_pins_o.iso_dac2_cs_n = (cfg_i.spi_mux == dmm_pkg::SPI_ISO_DAC2) ? cs2_n_i : 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/dmm_top.sv
// dmm front end control top: register bank, sequencer with mock adc, pin mux
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module dmm_top (
  input  wire                      clk_i,
  input  wire                      rst_n_i,
  input  wire                      sck_i,
  input  wire                      ss_n_i,
  input  wire                      sdi_i,
  input  wire                      spi_cs2_n_i,
  input  wire                      trig_sa_i,
  input  wire [`DMM_FLAGS_W-1:0]   hw_flags_i,
  output logic                     sdo_o,
  output dmm_pkg::pins_t           pins_o,
  output dmm_pkg::spi_pins_t       spi_pins_o
);

  dmm_pkg::dmm_cfg_t        cfg;               // quasi static, written with trig low
  dmm_pkg::pins_t           seq_pins;
  logic                     adc_reset_n;
  logic                     measure_valid;     // fan in from mock adc
  logic [`DMM_IDX_W-1:0]    sample_idx_last;

  //////////////////////////////////////////////////
  // sck domain

  spi_reg_bank u_spi_reg_bank (
    .sck_i             (sck_i),
    .cs_n_i            (ss_n_i),
    .mosi_i            (sdi_i),
    .rst_n_i           (rst_n_i),
    .miso_o            (sdo_o),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .cfg_o             (cfg)
  );

  //////////////////////////////////////////////////
  // clk domain

  acq_sequencer u_acq_sequencer (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .trig_sa_i         (trig_sa_i),
    .cfg_i             (cfg),
    .measure_valid_i   (measure_valid),
    .adc_reset_n_o     (adc_reset_n),
    .seq_pins_o        (seq_pins),
    .sample_idx_last_o (sample_idx_last)
  );

  adc_mock u_adc_mock (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .adc_reset_n_i   (adc_reset_n),
    .aperture_i      (cfg.aperture),
    .measure_valid_o (measure_valid)
  );

  // outputs, combinational from regs and pins
  pin_mux u_pin_mux (
    .cfg_i      (cfg),
    .seq_pins_i (seq_pins),
    .sck_i      (sck_i),
    .mosi_i     (sdi_i),
    .cs2_n_i    (spi_cs2_n_i),
    .pins_o     (pins_o),
    .spi_pins_o (spi_pins_o)
  );

endmodule

`default_nettype wire

// File: dv/dmm_props.sv
// bound checks on the dmm top: sample end pulse width, chip select exclusivity, unused modes
`timescale 1ns/10ps
`default_nettype none

module dmm_props (
  input wire                       clk_i,
  input wire                       rst_n_i,
  input wire dmm_pkg::dmm_cfg_t    cfg_i,
  input wire dmm_pkg::pins_t       seq_pins_i,
  input wire dmm_pkg::pins_t       pins_i,
  input wire dmm_pkg::spi_pins_t   spi_pins_i
);

  //////////////////////////////////////////////////
  // sequencer pulse, single cycle

  a_irq_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    seq_pins_i.spi_interrupt |=> !seq_pins_i.spi_interrupt)
    else $error("spi_interrupt held high for more than one cycle");

  // strobe counts as active high, dac selects active low
  a_one_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({spi_pins_i.strobe_4094, ~spi_pins_i.dac_cs_n,
              ~spi_pins_i.iso_dac_cs_n, ~spi_pins_i.iso_dac2_cs_n}))
    else $error("more than one peripheral chip select active");

  a_unused_mode_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cfg_i.mode != dmm_pkg::MODE_DIRECT && cfg_i.mode != dmm_pkg::MODE_ACQ_MOCK)
      |-> (pins_i == '0))
    else $error("board pins driven in an unused mode");

endmodule

bind dmm_top dmm_props u_dmm_props (
  .clk_i      (clk_i),
  .rst_n_i    (rst_n_i),
  .cfg_i      (cfg),
  .seq_pins_i (seq_pins),
  .pins_i     (pins_o),
  .spi_pins_i (spi_pins_o)
);

`default_nettype wire

// File: dv/dmm_tb.sv
// testbench for the dmm front end top: spi register access, pin modes, chip selects, sequencer
`timescale 1ns/10ps
`default_nettype none
`include "dmm_defs.svh"

module dmm_tb;

  localparam int CLK_PERIOD  = 4;
  localparam int FRAME_CYC   = 84;    // clk cycles per 40 bit spi frame
  localparam int N_FRAMES    = 64;    // all frames over all tests, rounded up
  localparam int ACQ_CYC     = 400;   // sequencer run budget
  localparam int N_SAMPLES   = 8;     // wraps a 3 word sequence twice, ends off index 0
  localparam int WATCHDOG_NS = CLK_PERIOD * (10 + FRAME_CYC * N_FRAMES + ACQ_CYC + 500);

  logic                      clk;
  logic                      rst_n;
  logic                      sck;
  logic                      ss_n;
  logic                      sdi;
  logic                      spi_cs2_n;
  logic                      trig;
  logic [`DMM_FLAGS_W-1:0]   hw_flags;
  logic                      sdo;
  dmm_pkg::pins_t            pins;
  dmm_pkg::spi_pins_t        spi_pins;

  dmm_pkg::dmm_cfg_t         model;       // what the register bank should hold
  logic [31:0]               lcg_state;
  logic [`DMM_IDX_W-1:0]     exp_idx;     // next sample index expected
  logic [`DMM_IDX_W-1:0]     last_idx;    // last completed sample seen
  logic                      acq_on;
  int                        n_samples;
  int                        n_checks;
  int                        n_errors;

  dmm_top uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .sck_i       (sck),
    .ss_n_i      (ss_n),
    .sdi_i       (sdi),
    .spi_cs2_n_i (spi_cs2_n),
    .trig_sa_i   (trig),
    .hw_flags_i  (hw_flags),
    .sdo_o       (sdo),
    .pins_o      (pins),
    .spi_pins_o  (spi_pins)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;   // numerical recipes constants
  endfunction

  // bits each register keeps, the rest read back as zero
  function automatic logic [31:0] field_mask(input int a);
    case (a)
      1:          return 32'h0000_000F;
      2, 4:       return 32'h0000_0007;
      3:          return 32'hFFFF_FFFF;
      5, 6, 7, 8: return 32'h0000_003F;
      9, 10:      return 32'h00FF_FFFF;
      default:    return 32'h0;
    endcase
  endfunction

  function automatic dmm_pkg::dmm_cfg_t model_write(input dmm_pkg::dmm_cfg_t c, input int a,
                                                   input logic [31:0] d);
    case (a)
      1:          c.spi_mux = dmm_pkg::spi_target_e'(d[3:0]);
      2:          c.mode = dmm_pkg::mode_e'(d[2:0]);
      3:          c.direct = d;
      4:          c.seq_n = d[2:0];
      5, 6, 7, 8: c.seq[a - 5] = d[5:0];
      9:          c.precharge = d[23:0];
      10:         c.aperture = d[23:0];
      default: ;
    endcase
    return c;
  endfunction

  // pins in direct mode, at a sample end pulse in acquire mode, zero otherwise
  function automatic dmm_pkg::pins_t ref_pins(input dmm_pkg::dmm_cfg_t c,
                                              input logic [`DMM_IDX_W-1:0] idx);
    dmm_pkg::pins_t p;
    p = '0;
    if (c.mode == dmm_pkg::MODE_DIRECT) begin
      p = dmm_pkg::pins_t'(c.direct[$bits(dmm_pkg::pins_t)-1:0]);
    end else if (c.mode == dmm_pkg::MODE_ACQ_MOCK) begin
      p.spi_interrupt = 1'b1;
      p.azmux   = c.seq[idx[1:0]][3:0];
      p.pc_sw   = c.seq[idx[1:0]][5:4];
      p.leds    = 4'b0001 << idx[1:0];
      p.monitor = {1'b0, idx, 1'b1, 1'b1, 2'(dmm_pkg::ACQ_MEASURE)};   // valid, adc running
    end
    return p;
  endfunction

  function automatic dmm_pkg::spi_pins_t ref_spi(input dmm_pkg::dmm_cfg_t c, input logic clk_in,
                                                 input logic mosi_in, input logic cs_n_in);
    dmm_pkg::spi_pins_t s;
    s.glb_clk       = (c.spi_mux == 4'b0000) ? 1'b1 : clk_in;    // parked high
    s.glb_mosi      = (c.spi_mux == 4'b0000) ? 1'b1 : mosi_in;
    s.strobe_4094   = (c.spi_mux == 4'b0001) ? ~cs_n_in : 1'b0;  // active high strobe
    s.dac_cs_n      = (c.spi_mux == 4'b0010) ? cs_n_in : 1'b1;
    s.iso_dac_cs_n  = (c.spi_mux == 4'b0100) ? cs_n_in : 1'b1;
    s.iso_dac2_cs_n = (c.spi_mux == 4'b1000) ? cs_n_in : 1'b1;
    return s;
  endfunction

  function automatic logic [31:0] ref_status(input dmm_pkg::dmm_cfg_t c, input logic [3:0] flags,
                                             input logic [`DMM_IDX_W-1:0] idx);
    return {9'b0, c.seq_n, 1'b0, idx, 4'(c.spi_mux), flags, 8'hAA};
  endfunction

  //////////////////////////////////////////////////
  // compare tasks

  task automatic check_word(input logic [`DMM_DATA_W-1:0] got, input logic [`DMM_DATA_W-1:0] exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t ns: %s got %h exp %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pins(input dmm_pkg::pins_t got, input dmm_pkg::pins_t exp,
                            input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t ns: %s pins got %h exp %h", $time, what, got, exp);
    end
  endtask

  task automatic check_spi(input dmm_pkg::spi_pins_t got, input dmm_pkg::spi_pins_t exp,
                           input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("MISMATCH %0t ns: %s spi pins got %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (n_errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, n_errors - errs_before);
    end
  endtask

  //////////////////////////////////////////////////
  // spi master, mode 0, two clk cycles per bit

  task automatic spi_frame(input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    logic [39:0] frame;
    frame = {addr, wdata};
    rdata = '0;
    @(negedge clk) ss_n = 1'b0;
    for (int i = 39; i >= 0; i--) begin
      @(negedge clk);
      sck = 1'b0;
      sdi = frame[i];
      @(negedge clk);
      if (i < 32) rdata[i] = sdo;   // sdo stable since the last sck fall
      sck = 1'b1;
    end
    @(negedge clk) sck = 1'b0;
    @(negedge clk) ss_n = 1'b1;
  endtask

  task automatic write_reg(input int a, input logic [31:0] d);
    logic [31:0] unused_rd;
    spi_frame({1'b1, 7'(a)}, d, unused_rd);
    model = model_write(model, a, d);
  endtask

  task automatic read_reg(input int a, output logic [31:0] d);
    spi_frame({1'b0, 7'(a)}, 32'h0, d);
  endtask

  // sample end pulses checked on the falling edge, pins settle after the rising one
  always @(negedge clk) begin
    if (acq_on && pins.spi_interrupt) begin
      check_pins(pins, ref_pins(model, exp_idx), $sformatf("sample %0d end", n_samples));
      last_idx = exp_idx;
      if (int'(exp_idx) + 1 >= ((model.seq_n == 0) ? 1 : int'(model.seq_n))) begin
        exp_idx = '0;   // wrap at seq_n
      end else begin
        exp_idx = exp_idx + 1'b1;
      end
      n_samples++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, run did not complete", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // tests

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic [3:0]  tgt;
    int          errs0;
    int          cyc;
    clk       = 1'b0;
    rst_n     = 1'b0;
    sck       = 1'b0;
    ss_n      = 1'b1;
    sdi       = 1'b0;
    spi_cs2_n = 1'b1;
    trig      = 1'b0;
    hw_flags  = '0;
    model     = '0;        // reset contents
    lcg_state = 32'h4619;
    exp_idx   = '0;
    last_idx  = '0;
    acq_on    = 1'b0;
    n_samples = 0;
    n_checks  = 0;
    n_errors  = 0;
    repeat (10) @(posedge clk);
    @(negedge clk) rst_n = 1'b1;

    errs0 = n_errors;
    @(posedge clk);
    check_pins(pins, ref_pins(model, '0), "after reset");
    check_spi(spi_pins, ref_spi(model, sck, sdi, spi_cs2_n), "after reset");
    report_test("reset state", errs0);

    errs0 = n_errors;   // random words through every writable register
    for (int round = 0; round < 2; round++) begin
      for (int a = 1; a <= 10; a++) begin
        lcg_state = lcg_step(lcg_state);
        wd = lcg_state;
        write_reg(a, wd);
        read_reg(a, rd);
        check_word(rd, wd & field_mask(a), $sformatf("reg %0d readback", a));
      end
    end
    report_test("register readback", errs0);

    errs0 = n_errors;
    lcg_state = lcg_step(lcg_state);
    @(negedge clk) hw_flags = lcg_state[3:0];
    write_reg(1, 32'h4);   // iso dac
    write_reg(4, 32'h3);
    read_reg(11, rd);
    check_word(rd, ref_status(model, hw_flags, last_idx), "status");
    report_test("status word", errs0);

    errs0 = n_errors;
    lcg_state = lcg_step(lcg_state);
    write_reg(2, 32'h0);
    write_reg(3, lcg_state);
    @(posedge clk) check_pins(pins, ref_pins(model, '0), "direct mode");
    write_reg(2, 32'h3);   // unused mode
    @(posedge clk) check_pins(pins, ref_pins(model, '0), "unused mode");
    report_test("pin modes", errs0);

    errs0 = n_errors;   // none, then each one-hot target
    for (int t = 0; t < 5; t++) begin
      tgt = (t == 0) ? 4'b0000 : 4'b0001 << (t - 1);
      write_reg(1, 32'(tgt));
      for (int cs = 0; cs < 2; cs++) begin
        @(negedge clk);
        spi_cs2_n = cs[0];
        sdi = cs[0] ^ t[0];   // both levels on every target
        sck = ~cs[0];         // frame logic held clear while ss_n high
        @(posedge clk);
        check_spi(spi_pins, ref_spi(model, sck, sdi, spi_cs2_n), $sformatf("target %b", tgt));
      end
      @(negedge clk);
      sck = 1'b0;
      sdi = 1'b0;
      spi_cs2_n = 1'b1;
    end
    report_test("chip select routing", errs0);

    errs0 = n_errors;
    write_reg(2, 32'h6);   // acquire with mock adc
    write_reg(4, 32'h3);
    for (int a = 5; a <= 8; a++) begin
      lcg_state = lcg_step(lcg_state);
      write_reg(a, lcg_state);
    end
    lcg_state = lcg_step(lcg_state);
    write_reg(9, 32'(lcg_state[2:0]) + 32'd2);
    write_reg(10, 32'(lcg_state[6:4]) + 32'd2);
    exp_idx = '0;
    acq_on  = 1'b1;
    @(negedge clk) trig = 1'b1;
    cyc = 0;
    while (n_samples < N_SAMPLES && cyc < ACQ_CYC) begin
      @(negedge clk);
      cyc++;
    end
    if (n_samples < N_SAMPLES) begin
      n_errors++;
      $display("ERROR %0t ns: only %0d sample end pulses in %0d cycles", $time, n_samples,
               ACQ_CYC);
    end
    trig = 1'b0;
    repeat (20) @(negedge clk);   // late pulse before idle still counts
    acq_on = 1'b0;
    read_reg(11, rd);
    check_word(rd, ref_status(model, hw_flags, last_idx), "status after run");
    report_test("acquire sequence", errs0);

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/dmm_pkg.sv
logic/spi_reg_bank.sv
logic/acq_sequencer.sv
logic/adc_mock.sv
logic/pin_mux.sv
logic/dmm_top.sv
dv/dmm_props.sv
dv/dmm_tb.sv

// File: Makefile
SIM        ?= verilator
TOP        ?= dmm_tb
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
